// ==== verilog/spi_pkg.sv ====
package spi_pkg;

  // ----------------------------------------
  // transfer geometry
  // ----------------------------------------
  localparam int data_width = 8;
  localparam int div_width  = 8;
  localparam int num_cs     = 4;

  // one launch and one sample edge per bit
  localparam int num_edges  = 2 * data_width;
  localparam int edge_width = $clog2(num_edges + 1);

  // half period of spi_clk is clk_div+1 sclk cycles
  localparam logic [div_width-1:0] clk_div_reset = 8'd3;

  // ----------------------------------------
  // register map, byte offsets
  // ----------------------------------------
  localparam logic [7:0] addr_ctrl   = 8'h00;
  localparam logic [7:0] addr_tx     = 8'h04;
  localparam logic [7:0] addr_rx     = 8'h08;
  localparam logic [7:0] addr_status = 8'h0C;

  // CTRL layout: cpol bit 0, cpha bit 1, cs_sel 3:2, clk_div 15:8
  localparam int ctrl_div_lsb = 8;

  typedef struct packed {
    logic                 cpol;
    logic                 cpha;
    logic [1:0]           cs_sel;
    logic [div_width-1:0] clk_div;
  } spi_cfg_t;

  // register block to engine
  typedef struct packed {
    logic                  start;
    logic [data_width-1:0] tx_byte;
  } spi_cmd_t;

  // engine back to register block
  typedef struct packed {
    logic                  done;
    logic [data_width-1:0] rx_byte;
  } spi_rsp_t;

  typedef struct packed {
    logic              spi_clk;
    logic              mosi;
    logic [num_cs-1:0] cs_n;
  } spi_pins_t;

endpackage

// ==== verilog/spi_apb_regs.sv ====
module spi_apb_regs (
  input  logic                sclk,
  input  logic                reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [7:0]          paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  input  logic                busy,
  input  spi_pkg::spi_rsp_t   rsp,
  output spi_pkg::spi_cfg_t   cfg,
  output spi_pkg::spi_cmd_t   cmd
);

  logic access;
  logic hit_ctrl;
  logic hit_tx;
  logic hit_rx;
  logic hit_status;
  logic addr_hit;
  logic err;
  logic tx_accept;
  logic [spi_pkg::data_width-1:0] tx_hold;
  logic [spi_pkg::data_width-1:0] rx_hold;

  // ----------------------------------------
  // APB decode
  // ----------------------------------------
  assign access     = psel && penable;
  assign hit_ctrl   = (paddr == spi_pkg::addr_ctrl);
  assign hit_tx     = (paddr == spi_pkg::addr_tx);
  assign hit_rx     = (paddr == spi_pkg::addr_rx);
  assign hit_status = (paddr == spi_pkg::addr_status);
  assign addr_hit   = hit_ctrl || hit_tx || hit_rx || hit_status;

  // bad offset, write to a read-only reg, or TX while a byte is in flight
  assign err = access && (!addr_hit ||
                          (pwrite && (hit_rx || hit_status)) ||
                          (pwrite && hit_tx && busy));

  assign tx_accept = access && pwrite && hit_tx && !busy;

  assign pready  = 1'b1;
  assign pslverr = err;

  // start goes out in the access cycle so busy follows one cycle later
  assign cmd.start   = tx_accept;
  assign cmd.tx_byte = pwdata[spi_pkg::data_width-1:0];

  always_comb begin
    prdata = '0;
    if (access && !pwrite && !err) begin
      case (paddr)
        spi_pkg::addr_ctrl: begin
          prdata[0]   = cfg.cpol;
          prdata[1]   = cfg.cpha;
          prdata[3:2] = cfg.cs_sel;
          prdata[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width] = cfg.clk_div;
        end
        spi_pkg::addr_tx:     prdata[spi_pkg::data_width-1:0] = tx_hold;
        spi_pkg::addr_rx:     prdata[spi_pkg::data_width-1:0] = rx_hold;
        spi_pkg::addr_status: prdata[0] = busy;
        default:              prdata = '0;
      endcase
    end
  end

  // ----------------------------------------
  // CTRL register
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      cfg <= '{cpol: 1'b0, cpha: 1'b0, cs_sel: 2'b00, clk_div: spi_pkg::clk_div_reset};
    end else if (access && pwrite && hit_ctrl) begin
      cfg.cpol    <= pwdata[0];
      cfg.cpha    <= pwdata[1];
      cfg.cs_sel  <= pwdata[3:2];
      cfg.clk_div <= pwdata[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width];
    end
  end

  // last byte sent and last byte received
  always_ff @(posedge sclk) begin
    if (tx_accept) begin
      tx_hold <= pwdata[spi_pkg::data_width-1:0];
    end
    if (rsp.done) begin
      rx_hold <= rsp.rx_byte;
    end
  end

  // an accepted start always finds the engine idle and wakes it
  start_only_when_idle: assert property (
    @(posedge sclk) disable iff (reset)
    cmd.start |-> !busy ##1 busy
  );

endmodule

// ==== verilog/spi_shift_engine.sv ====
module spi_shift_engine (
  input  logic               sclk,
  input  logic               reset,
  input  spi_pkg::spi_cfg_t  cfg,
  input  spi_pkg::spi_cmd_t  cmd,
  input  logic               miso,
  output spi_pkg::spi_pins_t pins,
  output logic               busy,
  output spi_pkg::spi_rsp_t  rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_shift,
    st_hold
  } state_t;

  state_t state;
  spi_pkg::spi_cfg_t cfg_q;

  logic [spi_pkg::div_width-1:0]  div_cnt;
  logic                           tick;
  logic [spi_pkg::edge_width-1:0] edge_cnt;
  logic [spi_pkg::edge_width-1:0] edge_next;
  logic                           sample_edge;
  logic                           clk_lvl;
  logic [spi_pkg::num_cs-1:0]     cs_n_q;
  logic                           done_q;
  logic [spi_pkg::data_width-1:0] tx_sh;
  logic [spi_pkg::data_width-1:0] rx_sh;
  logic                           miso_meta;
  logic                           miso_sync;

  assign tick      = (div_cnt == '0);
  assign edge_next = edge_cnt + 1'b1;

  // odd edges are leading; cpha 0 samples there, cpha 1 on trailing
  assign sample_edge = edge_next[0] ^ cfg_q.cpha;

  // ----------------------------------------
  // sequencer
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      state    <= st_idle;
      div_cnt  <= '0;
      edge_cnt <= '0;
      clk_lvl  <= 1'b0;
      cs_n_q   <= '1;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state != st_idle) begin
        div_cnt <= tick ? cfg_q.clk_div : div_cnt - 1'b1;
      end
      case (state)
        st_idle: begin
          if (cmd.start) begin
            state    <= st_setup;
            div_cnt  <= cfg.clk_div;
            edge_cnt <= '0;
            clk_lvl  <= 1'b0;
            cs_n_q   <= ~(spi_pkg::num_cs'(1) << cfg.cs_sel);
          end
        end
        // one half period with cs_n low before the first edge
        st_setup: begin
          if (tick) begin
            state <= st_shift;
          end
        end
        st_shift: begin
          if (tick) begin
            clk_lvl  <= ~clk_lvl;
            edge_cnt <= edge_next;
            if (edge_next == spi_pkg::edge_width'(spi_pkg::num_edges)) begin
              state <= st_hold;
            end
          end
        end
        st_hold: begin
          if (tick) begin
            state  <= st_idle;
            cs_n_q <= '1;
            done_q <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // data path
  // ----------------------------------------
  // miso latency is two cycles, so clk_div below 2 samples a stale bit
  always_ff @(posedge sclk) begin
    miso_meta <= miso;
    miso_sync <= miso_meta;
    if (state == st_idle && cmd.start) begin
      cfg_q <= cfg;
      tx_sh <= cmd.tx_byte;
    end else if (state == st_shift && tick) begin
      if (sample_edge) begin
        rx_sh <= {rx_sh[spi_pkg::data_width-2:0], miso_sync};
      end else if (edge_next != spi_pkg::edge_width'(1)) begin
        // MSB already sits on mosi for the first launch edge of cpha 1
        tx_sh <= {tx_sh[spi_pkg::data_width-2:0], 1'b0};
      end
    end
  end

  // idle level follows live CTRL, the transfer uses the sampled copy
  assign pins.spi_clk = (state == st_idle) ? cfg.cpol : (cfg_q.cpol ^ clk_lvl);
  assign pins.mosi    = (state != st_idle) && tx_sh[spi_pkg::data_width-1];
  assign pins.cs_n    = cs_n_q;

  assign busy        = (state != st_idle);
  assign rsp.done    = done_q;
  assign rsp.rx_byte = rx_sh;

  one_cs_while_busy: assert property (
    @(posedge sclk) disable iff (reset)
    busy |-> $onehot(~pins.cs_n)
  );

  edge_count_bound: assert property (
    @(posedge sclk) disable iff (reset)
    edge_cnt <= spi_pkg::edge_width'(spi_pkg::num_edges)
  );

endmodule

// ==== verilog/spi_bus_checker.sv ====
module spi_bus_checker (
  input logic               sclk,
  input logic               reset,
  input spi_pkg::spi_pins_t pins,
  input logic               miso,
  input spi_pkg::spi_cfg_t  cfg
);

  logic prev_clk;
  logic cs_active;
  logic leading;
  logic trailing;
  logic sample_edge;

  always_ff @(posedge sclk) begin
    if (reset) begin
      prev_clk <= 1'b0;
    end else begin
      prev_clk <= pins.spi_clk;
    end
  end

  // ----------------------------------------
  // edge classification for current mode
  // ----------------------------------------
  assign cs_active = ~&pins.cs_n;
  assign leading   = (prev_clk == cfg.cpol) && (pins.spi_clk != cfg.cpol);
  assign trailing  = (prev_clk != cfg.cpol) && (pins.spi_clk == cfg.cpol);

  assign sample_edge = cs_active && (cfg.cpha ? trailing : leading);

  // ----------------------------------------
  // pin rules
  // ----------------------------------------
  clk_idle_when_deselected: assert property (
    @(posedge sclk) disable iff (reset)
    &pins.cs_n |-> pins.spi_clk == cfg.cpol
  );

  // mosi only moves on launch edges
  mosi_stable_at_sample: assert property (
    @(posedge sclk) disable iff (reset)
    sample_edge |-> $stable(pins.mosi)
  );

  cs_stable_while_clk_active: assert property (
    @(posedge sclk) disable iff (reset)
    pins.spi_clk != cfg.cpol |-> $stable(pins.cs_n)
  );

  // slave must drive a real level when we sample it
  miso_known_at_sample: assert property (
    @(posedge sclk) disable iff (reset)
    sample_edge |-> !$isunknown(miso)
  );

endmodule

// ==== verilog/spi_master_top.sv ====
module spi_master_top (
  input  logic                       sclk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [7:0]                 paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  logic                       miso,
  output logic                       spi_clk,
  output logic                       mosi,
  output logic [spi_pkg::num_cs-1:0] cs_n
);

  spi_pkg::spi_cfg_t  cfg;
  spi_pkg::spi_cmd_t  cmd;
  spi_pkg::spi_rsp_t  rsp;
  spi_pkg::spi_pins_t pins;
  logic               busy;

  spi_apb_regs u_regs (
    .sclk    (sclk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .busy    (busy),
    .rsp     (rsp),
    .cfg     (cfg),
    .cmd     (cmd)
  );

  spi_shift_engine u_engine (
    .sclk  (sclk),
    .reset (reset),
    .cfg   (cfg),
    .cmd   (cmd),
    .miso  (miso),
    .pins  (pins),
    .busy  (busy),
    .rsp   (rsp)
  );

  spi_bus_checker u_checker (
    .sclk  (sclk),
    .reset (reset),
    .pins  (pins),
    .miso  (miso),
    .cfg   (cfg)
  );

  assign spi_clk = pins.spi_clk;
  assign mosi    = pins.mosi;
  assign cs_n    = pins.cs_n;

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic sclk,
  output logic reset
);

  // 8 time unit period
  initial begin
    sclk = 1'b0;
    forever begin
      #4 sclk = ~sclk;
    end
  end

  // reset held for the first 10 rising edges
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge sclk);
    reset <= 1'b0;
  end

endmodule

// ==== test/tb_spi_master.sv ====
module tb_spi_master;

  logic        sclk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        miso = 1'b0;
  logic        spi_clk;
  logic        mosi;
  logic [3:0]  cs_n;

  // slave model mode as of the last CTRL write
  logic       mode_cpol;
  logic       mode_cpha;
  logic [1:0] mode_cs;

  // slave model state
  logic       prev_clk;
  logic [3:0] prev_cs;
  logic [7:0] slave_byte;
  logic [7:0] slave_sh;
  logic [7:0] slave_rx;

  int checks;
  int errors;

  tb_clock_gen u_clock_gen (
    .sclk  (sclk),
    .reset (reset)
  );

  spi_master_top u_spi_master_top (
    .sclk    (sclk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .miso    (miso),
    .spi_clk (spi_clk),
    .mosi    (mosi),
    .cs_n    (cs_n)
  );

  // ----------------------------------------
  // SPI slave model
  // ----------------------------------------
  always @(posedge sclk) begin
    if (reset) begin
      miso     <= 1'b0;
      prev_clk <= 1'b0;
      prev_cs  <= 4'hf;
      slave_sh <= 8'h00;
      slave_rx <= 8'h00;
    end else begin
      prev_clk <= spi_clk;
      prev_cs  <= cs_n;
      if (&prev_cs && !(&cs_n)) begin
        // cpha 0 needs the MSB on miso before the first edge
        if (mode_cpha) begin
          slave_sh <= slave_byte;
        end else begin
          miso     <= slave_byte[7];
          slave_sh <= {slave_byte[6:0], 1'b0};
        end
      end else if (!(&cs_n) && spi_clk != prev_clk) begin
        if ((prev_clk == mode_cpol) ^ mode_cpha) begin
          slave_rx <= {slave_rx[6:0], mosi};
        end else begin
          miso     <= slave_sh[7];
          slave_sh <= {slave_sh[6:0], 1'b0};
        end
      end
    end
  end

  // ----------------------------------------
  // pin checks
  // ----------------------------------------
  cs_follows_select: assert property (
    @(posedge sclk) disable iff (reset)
    cs_n != 4'hf |-> cs_n == ~(4'b0001 << mode_cs)
  ) else begin
    errors++;
    $display("FAILED cs_select: expected %b actual %b",
             ~(4'b0001 << mode_cs), $sampled(cs_n));
  end

  clk_idles_at_cpol: assert property (
    @(posedge sclk) disable iff (reset)
    cs_n == 4'hf |-> spi_clk == mode_cpol
  ) else begin
    errors++;
    $display("FAILED clk_idle: expected %b actual %b", mode_cpol, $sampled(spi_clk));
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s: expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic end_of_run;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // one APB transfer with the response sampled mid access phase
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    @(posedge sclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge sclk);
    penable <= 1'b1;
    @(negedge sclk);
    check_value("pready", 1, pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge sclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
    apb_access(1'b0, addr, 32'h0, rdata, err);
  endtask

  function automatic logic [31:0] ctrl_word(input logic cpol, input logic cpha,
                                            input logic [1:0] cs, input logic [7:0] div);
    return {16'h0000, div, 4'h0, cs, cpha, cpol};
  endfunction

  task automatic wait_reset_release;
    int cycles;
    cycles = 0;
    while (reset !== 1'b0 && cycles < 100) begin
      @(posedge sclk);
      cycles++;
    end
    if (reset !== 1'b0) begin
      errors++;
      $display("reset was never released");
      end_of_run();
    end
  endtask

  // polls STATUS every three cycles
  task automatic wait_idle(input string name);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    cycles = 0;
    rdata  = 32'h1;
    while (rdata[0] && cycles < 2000) begin
      apb_read(spi_pkg::addr_status, rdata, err);
      cycles += 3;
    end
    if (rdata[0]) begin
      errors++;
      $display("%s: busy did not clear within 2000 cycles", name);
      end_of_run();
    end
  endtask

  task automatic run_transfer(input logic cpol, input logic cpha, input logic [1:0] cs,
                              input logic [7:0] div, input logic collide);
    logic [31:0] rdata;
    logic        err;
    logic [7:0]  tx_byte;
    tx_byte = 8'($urandom);
    $display("transfer cpol %0d cpha %0d cs %0d div %0d", cpol, cpha, cs, div);
    apb_write(spi_pkg::addr_ctrl, ctrl_word(cpol, cpha, cs, div), err);
    check_value("ctrl_write_err", 0, err);
    mode_cpol  = cpol;
    mode_cpha  = cpha;
    mode_cs    = cs;
    slave_byte = 8'($urandom);
    apb_write(spi_pkg::addr_tx, {24'h0, tx_byte}, err);
    check_value("tx_write_err", 0, err);
    if (collide) begin
      apb_write(spi_pkg::addr_tx, {24'h0, ~tx_byte}, err);
      check_value("tx_busy_err", 1, err);
    end
    wait_idle("transfer");
    @(negedge sclk);
    check_value("cs_release", 4'hf, cs_n);
    check_value("mosi_capture", tx_byte, slave_rx);
    apb_read(spi_pkg::addr_rx, rdata, err);
    check_value("rx_readback", slave_byte, rdata);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] rdata;
    logic        err;
    int          m;
    int          d;
    void'($urandom(32'h1ad3));
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = 8'h00;
    pwdata     = 32'h0;
    mode_cpol  = 1'b0;
    mode_cpha  = 1'b0;
    mode_cs    = 2'd0;
    slave_byte = 8'h00;
    checks     = 0;
    errors     = 0;
    wait_reset_release();

    // reset values
    apb_read(spi_pkg::addr_ctrl, rdata, err);
    check_value("reset_ctrl", ctrl_word(1'b0, 1'b0, 2'd0, 8'd3), rdata);
    apb_read(spi_pkg::addr_status, rdata, err);
    check_value("reset_status", 0, rdata);
    @(negedge sclk);
    check_value("reset_cs_n", 4'hf, cs_n);
    check_value("reset_spi_clk", 0, spi_clk);

    // all four modes, two divider settings
    for (m = 0; m < 4; m++) begin
      for (d = 0; d < 2; d++) begin
        run_transfer(m[0], m[1], 2'((m + d) % 4), (d == 0) ? 8'd3 : 8'd6, 1'b0);
      end
    end

    // TX write while busy
    run_transfer(1'b1, 1'b1, 2'd3, 8'd4, 1'b1);

    // bad offset
    apb_read(8'h10, rdata, err);
    check_value("bad_addr_err", 1, err);
    check_value("bad_addr_rdata", 0, rdata);
    apb_write(8'h10, 32'hffff_ffff, err);
    check_value("bad_addr_write_err", 1, err);

    // read-only registers
    apb_write(spi_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0, 2'd2, 8'd5), err);
    mode_cpol = 1'b1;
    mode_cpha = 1'b0;
    mode_cs   = 2'd2;
    apb_write(spi_pkg::addr_rx, 32'hffff_ffff, err);
    check_value("rx_write_err", 1, err);
    apb_write(spi_pkg::addr_status, 32'hffff_ffff, err);
    check_value("status_write_err", 1, err);
    apb_read(spi_pkg::addr_ctrl, rdata, err);
    check_value("ctrl_unchanged", ctrl_word(1'b1, 1'b0, 2'd2, 8'd5), rdata);

    end_of_run();
  end

endmodule

// ==== sources.f ====
verilog/spi_pkg.sv
verilog/spi_apb_regs.sv
verilog/spi_shift_engine.sv
verilog/spi_bus_checker.sv
verilog/spi_master_top.sv
test/tb_clock_gen.sv
test/tb_spi_master.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  # rtl, package first
  - verilog/spi_pkg.sv
  - verilog/spi_apb_regs.sv
  - verilog/spi_shift_engine.sv
  - verilog/spi_bus_checker.sv
  - verilog/spi_master_top.sv

  # testbench
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_spi_master.sv
